// File: zs_top.f
design/zs_pixel_pkg.sv
design/zs_fifo_pkg.sv
design/zs_read_if.sv
design/zs_run_encoder.sv
design/zs_word_store.sv
design/zs_run_expander.sv
design/zs_top.sv
verif/zs_chk.sv
verif/zs_monitor.sv
verif/zs_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the zs_top testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module zs_tb -f zs_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vzs_tb > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL TESTS PASSED" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

// File: verif/zs_tb.sv
`timescale 1ns/10ps
`default_nettype none

module zs_tb;

    localparam int K_PIX  = 0;
    localparam int K_NULL = 1;
    localparam int K_FEND = 2;
    localparam int K_IDLE = 3;
    localparam int N_ENT  = 16;

    // each row is applied rep times
    // a zero pixel value asks for a random pixel
    typedef struct {
        int                             kind;
        int                             rep;
        logic [zs_pixel_pkg::PIX_W-1:0] value;
        logic                           drain;
        int                             exp_err;
    } stim_t;

    logic                            clk;
    logic                            rstb;
    logic                            pix_valid_in;
    logic [zs_pixel_pkg::PIX_W-1:0]  pix_in;
    logic                            frame_end;
    logic                            drain;
    logic                            pix_valid_out;
    logic [zs_pixel_pkg::PIX_W-1:0]  pix_out;
    logic [zs_fifo_pkg::COUNT_W-1:0] num_elem;
    logic                            err_overwr;
    logic                            end_check;
    int                              exp_err_total;
    int                              value_errs;
    int                              flow_errs;
    int                              pending;
    int                              cycles;
    int                              limit;
    logic [31:0]                     rnd;
    stim_t                           stim [N_ENT];

    zs_top uut (.*);

    zs_monitor mon (.*);

    bind zs_top zs_chk u_chk (
        .clk           (clk),
        .rstb          (rstb),
        .pix_valid_out (pix_valid_out),
        .pix_out       (pix_out),
        .num_elem      (num_elem),
        .err_overwr    (err_overwr),
        .run_flag      (rd_if.rd_word.run.flag)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one strobe or pulse, then an idle cycle
    task automatic apply_entry(input stim_t e);
        logic [zs_pixel_pkg::PIX_W-1:0] pix;
        pix = e.value;
        if (e.kind == K_PIX && pix == zs_pixel_pkg::NULL_PIXEL) begin
            rnd = lcg_next(rnd);
            pix = (rnd[30:10] == '0) ? 21'h1 : rnd[30:10];
        end
        @(posedge clk);
        #10;
        drain        = e.drain;
        pix_valid_in = (e.kind == K_PIX) || (e.kind == K_NULL);
        pix_in       = (e.kind == K_PIX) ? pix : zs_pixel_pkg::NULL_PIXEL;
        frame_end    = (e.kind == K_FEND);
        @(posedge clk);
        #10;
        pix_valid_in = 1'b0;
        frame_end    = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Run stopped after %0d cycles with output still missing", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int total;
        int max_run;
        // plain data, then runs of 1, 2, 7 and 300, partly with drain low
        stim[0]  = '{K_PIX,  6,   21'h0,      1'b1, 0};
        stim[1]  = '{K_PIX,  1,   21'h0abcd,  1'b0, 0};
        stim[2]  = '{K_NULL, 1,   21'h0,      1'b0, 0};
        stim[3]  = '{K_PIX,  1,   21'h0,      1'b0, 0};
        stim[4]  = '{K_NULL, 2,   21'h0,      1'b0, 0};
        stim[5]  = '{K_PIX,  1,   21'h0,      1'b0, 0};
        stim[6]  = '{K_NULL, 7,   21'h0,      1'b1, 0};
        stim[7]  = '{K_PIX,  1,   21'h0,      1'b1, 0};
        stim[8]  = '{K_NULL, 300, 21'h0,      1'b1, 0};
        stim[9]  = '{K_PIX,  1,   21'h1fffff, 1'b1, 0};
        // drain dropped mid-stream and a trailing run closed by frame end
        stim[10] = '{K_NULL, 5,   21'h0,      1'b0, 0};
        stim[11] = '{K_FEND, 1,   21'h0,      1'b0, 0};
        // more data, then drain resumed
        stim[12] = '{K_PIX,  4,   21'h0,      1'b0, 0};
        stim[13] = '{K_PIX,  2,   21'h0,      1'b1, 0};
        // empty the store, then overflow it
        stim[14] = '{K_IDLE, 250, 21'h0,      1'b1, 0};
        stim[15] = '{K_PIX,  520, 21'h0,      1'b0, 9};
        rstb          = 1'b0;
        pix_valid_in  = 1'b0;
        pix_in        = '0;
        frame_end     = 1'b0;
        drain         = 1'b0;
        end_check     = 1'b0;
        rnd           = 32'he346f0af;
        cycles        = 0;
        total         = 0;
        max_run       = 0;
        exp_err_total = 0;
        foreach (stim[i]) begin
            total         += stim[i].rep;
            exp_err_total += stim[i].exp_err;
            if (stim[i].kind == K_NULL && stim[i].rep > max_run) begin
                max_run = stim[i].rep;
            end
        end
        limit = 2 * total * 2 + max_run + 100;
        repeat (5) @(posedge clk);
        #10;
        rstb = 1'b1;
        foreach (stim[i]) begin
            repeat (stim[i].rep) apply_entry(stim[i]);
        end
        drain = 1'b1;
        while (pending != 0 || num_elem != 0) begin
            @(posedge clk);
            #10;
        end
        // room for stray output pixels
        repeat (4) @(posedge clk);
        #10;
        end_check = 1'b1;
        repeat (2) @(posedge clk);
        #10;
        $display("errors: %0d value mismatches, %0d missing or extra outputs, %0d assertions",
                 value_errs, flow_errs, uut.u_chk.fail_cnt);
        if (value_errs + flow_errs + uut.u_chk.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/zs_monitor.sv
`timescale 1ns/10ps
`default_nettype none

module zs_monitor (
    input  logic                            clk,
    input  logic                            rstb,
    input  logic                            pix_valid_in,
    input  logic [zs_pixel_pkg::PIX_W-1:0]  pix_in,
    input  logic                            frame_end,
    input  logic                            drain,
    input  logic                            pix_valid_out,
    input  logic [zs_pixel_pkg::PIX_W-1:0]  pix_out,
    input  logic [zs_fifo_pkg::COUNT_W-1:0] num_elem,
    input  logic                            err_overwr,
    input  logic                            end_check,
    input  int                              exp_err_total,
    output int                              value_errs,
    output int                              flow_errs,
    output int                              pending
);

    logic [zs_pixel_pkg::PIX_W-1:0]  exp_q [$];
    logic [zs_pixel_pkg::PIX_W-1:0]  run_cnt;
    logic [zs_pixel_pkg::PIX_W-1:0]  hold_pix;
    logic [zs_pixel_pkg::PIX_W-1:0]  wr_val;
    logic [zs_pixel_pkg::PIX_W-1:0]  exp_pix;
    logic [zs_fifo_pkg::COUNT_W-1:0] model_cnt;
    logic [zs_fifo_pkg::COUNT_W-1:0] base;
    logic                            hold;
    logic                            wr_now;
    logic                            wr_run;
    logic                            model_ok;
    logic                            drop;
    logic                            end_done;
    int                              err_pulses;

    // values seen here are those of the cycle that just ended
    always @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            exp_q.delete();
            run_cnt    = '0;
            hold       = 1'b0;
            wr_now     = 1'b0;
            model_ok   = 1'b0;
            end_done   = 1'b0;
            err_pulses = 0;
            value_errs = 0;
            flow_errs  = 0;
            pending    = 0;
        end else begin
            // count is predictable only while no read can happen
            base = model_ok ? model_cnt : num_elem;
            if (model_ok && num_elem !== model_cnt) begin
                $display("Fail num_elem: expected %h, got %h", model_cnt, num_elem);
                value_errs++;
            end
            drop = wr_now && (base == zs_fifo_pkg::FULL_COUNT);
            if (err_overwr !== drop) begin
                $display("Fail err_overwr: expected %h, got %h", drop, err_overwr);
                value_errs++;
            end
            if (err_overwr) begin
                err_pulses++;
            end
            model_cnt = (wr_now && !drop) ? base + 1'b1 : base;
            model_ok  = !drain;
            // stored words come back out in order
            if (wr_now && !drop) begin
                if (wr_run) begin
                    repeat (wr_val) exp_q.push_back(zs_pixel_pkg::NULL_PIXEL);
                end else begin
                    exp_q.push_back(wr_val);
                end
            end
            if (pix_valid_out) begin
                if (exp_q.size() == 0) begin
                    $display("Output pixel %h arrived with nothing left to expect", pix_out);
                    flow_errs++;
                end else begin
                    exp_pix = exp_q.pop_front();
                    if (pix_out !== exp_pix) begin
                        $display("Fail pix_out: expected %h, got %h", exp_pix, pix_out);
                        value_errs++;
                    end
                end
            end
            // encoder rule, write for the coming cycle
            wr_now = 1'b1;
            wr_run = 1'b0;
            wr_val = pix_in;
            if (hold) begin
                wr_val = hold_pix;
                hold   = 1'b0;
            end else if (pix_valid_in && pix_in != zs_pixel_pkg::NULL_PIXEL && run_cnt != '0) begin
                wr_run   = 1'b1;
                wr_val   = run_cnt;
                hold     = 1'b1;
                hold_pix = pix_in;
                run_cnt  = '0;
            end else if (pix_valid_in && pix_in == zs_pixel_pkg::NULL_PIXEL) begin
                run_cnt = run_cnt + 1'b1;
                wr_now  = 1'b0;
            end else if (frame_end && run_cnt != '0) begin
                wr_run  = 1'b1;
                wr_val  = run_cnt;
                run_cnt = '0;
            end else begin
                // data pixel with no run open, or nothing at all
                wr_now = pix_valid_in;
            end
            pending = exp_q.size();
            if (end_check && !end_done) begin
                end_done = 1'b1;
                if (exp_q.size() != 0) begin
                    $display("%0d expected pixels never reached the output", exp_q.size());
                    flow_errs++;
                end
                if (err_pulses != exp_err_total) begin
                    $display("Fail err_overwr pulses: expected %h, got %h",
                             exp_err_total, err_pulses);
                    value_errs++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/zs_chk.sv
`timescale 1ns/10ps
`default_nettype none

module zs_chk (
    input logic                            clk,
    input logic                            rstb,
    input logic                            pix_valid_out,
    input logic [zs_pixel_pkg::PIX_W-1:0]  pix_out,
    input logic [zs_fifo_pkg::COUNT_W-1:0] num_elem,
    input logic                            err_overwr,
    input logic                            run_flag
);

    int fail_cnt = 0;

    // overwrite error only at the full level
    err_at_full: assert property (@(posedge clk) disable iff (!rstb)
        err_overwr |-> num_elem == zs_fifo_pkg::FULL_COUNT)
        else begin
            $error("err_overwr raised while num_elem is %0d", num_elem);
            fail_cnt++;
        end

    // a full store never wraps its count past the full level
    count_in_range: assert property (@(posedge clk) disable iff (!rstb)
        num_elem == zs_fifo_pkg::FULL_COUNT |=> num_elem >= zs_fifo_pkg::FULL_COUNT - 1'b1)
        else begin
            $error("num_elem %0d after the full level", num_elem);
            fail_cnt++;
        end

    // pixels rebuilt from a run word are always null
    run_is_null: assert property (@(posedge clk) disable iff (!rstb)
        pix_valid_out && run_flag |-> pix_out == zs_pixel_pkg::NULL_PIXEL)
        else begin
            $error("non-null pixel %h rebuilt from a run word", pix_out);
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk) !rstb |-> !pix_valid_out)
        else begin
            $error("pix_valid_out high during reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// File: design/zs_top.sv
`timescale 1ns/10ps
`default_nettype none

module zs_top (
    input  logic                              clk,
    input  logic                              rstb,
    input  logic                              pix_valid_in,
    input  logic [zs_pixel_pkg::PIX_W-1:0]    pix_in,
    input  logic                              frame_end,
    input  logic                              drain,
    output logic                              pix_valid_out,
    output logic [zs_pixel_pkg::PIX_W-1:0]    pix_out,
    output logic [zs_fifo_pkg::COUNT_W-1:0]   num_elem,
    output logic                              err_overwr
);

    logic                   wr_en;
    zs_pixel_pkg::zs_word_u wr_word;

    zs_read_if rd_if ();

    assign num_elem = rd_if.num_elem;

    zs_run_encoder u_encoder (
        .clk          (clk),
        .rstb         (rstb),
        .pix_valid_in (pix_valid_in),
        .pix_in       (pix_in),
        .frame_end    (frame_end),
        .wr_en        (wr_en),
        .wr_word      (wr_word)
    );

    zs_word_store u_store (
        .clk        (clk),
        .rstb       (rstb),
        .wr_en      (wr_en),
        .wr_word    (wr_word),
        .rd         (rd_if.store),
        .err_overwr (err_overwr)
    );

    zs_run_expander u_expander (
        .clk           (clk),
        .rstb          (rstb),
        .drain         (drain),
        .rd            (rd_if.expander),
        .pix_valid_out (pix_valid_out),
        .pix_out       (pix_out)
    );

endmodule

`default_nettype wire

// File: design/zs_run_expander.sv
`timescale 1ns/10ps
`default_nettype none

module zs_run_expander (
    input  logic                            clk,
    input  logic                            rstb,
    input  logic                            drain,
    zs_read_if.expander                     rd,
    output logic                            pix_valid_out,
    output logic [zs_pixel_pkg::PIX_W-1:0]  pix_out
);

    enum logic [1:0] {S_IDLE, S_DECODE, S_RUN} state;

    logic [zs_pixel_pkg::PIX_W-1:0] remain;
    logic [zs_pixel_pkg::PIX_W-1:0] remain_dec;
    logic [zs_pixel_pkg::PIX_W-1:0] run_left;
    logic                           is_run;

    // new reads only when idle, drain only holds back this request
    assign rd.rd_en = (state == S_IDLE) && drain && !rd.empty;

    assign is_run     = (rd.rd_word.run.flag == zs_pixel_pkg::RUN_FLAG);
    assign run_left   = rd.rd_word.run.count - 1'b1;
    assign remain_dec = remain - 1'b1;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state         <= S_IDLE;
            remain        <= '0;
            pix_valid_out <= 1'b0;
        end else begin
            pix_valid_out <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (rd.rd_en) begin
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    // first pixel of either kind of word
                    pix_valid_out <= 1'b1;
                    if (is_run && (run_left != '0)) begin
                        remain <= run_left;
                        state  <= S_RUN;
                    end else begin
                        state <= S_IDLE;
                    end
                end
                S_RUN: begin
                    pix_valid_out <= 1'b1;
                    remain        <= remain_dec;
                    if (remain_dec == '0) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // pixel value stays null for the rest of a run
    always_ff @(posedge clk) begin
        if (state == S_DECODE) begin
            pix_out <= is_run ? zs_pixel_pkg::NULL_PIXEL : rd.rd_word.data.pixel;
        end
    end

endmodule

`default_nettype wire

// File: design/zs_word_store.sv
`timescale 1ns/10ps
`default_nettype none

module zs_word_store (
    input  logic                    clk,
    input  logic                    rstb,
    input  logic                    wr_en,
    input  zs_pixel_pkg::zs_word_u  wr_word,
    zs_read_if.store                rd,
    output logic                    err_overwr
);

    zs_pixel_pkg::zs_word_u mem [zs_fifo_pkg::DEPTH];

    logic [zs_fifo_pkg::ADDR_W-1:0]  wr_head;
    logic [zs_fifo_pkg::ADDR_W-1:0]  rd_head;
    logic [zs_fifo_pkg::COUNT_W-1:0] count;
    logic                            full;
    logic                            do_wr;
    logic                            do_rd;

    assign full  = (count == zs_fifo_pkg::FULL_COUNT);
    assign do_wr = wr_en && !full;
    assign do_rd = rd.rd_en && !rd.empty;

    // write into a full store is dropped and flagged
    assign err_overwr = wr_en && full;

    assign rd.num_elem = count;
    assign rd.empty    = (count == '0);

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            wr_head <= '0;
            rd_head <= '0;
            count   <= '0;
        end else begin
            if (do_wr) begin
                wr_head <= wr_head + 1'b1;
            end
            if (do_rd) begin
                rd_head <= rd_head + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // word memory, registered read port
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_head] <= wr_word;
        end
        if (do_rd) begin
            rd.rd_word <= mem[rd_head];
        end
    end

endmodule

`default_nettype wire

// File: design/zs_run_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module zs_run_encoder (
    input  logic                            clk,
    input  logic                            rstb,
    input  logic                            pix_valid_in,
    input  logic [zs_pixel_pkg::PIX_W-1:0]  pix_in,
    input  logic                            frame_end,
    output logic                            wr_en,
    output zs_pixel_pkg::zs_word_u          wr_word
);

    enum logic [1:0] {S_IDLE, S_COUNT, S_HOLD} state;

    logic [zs_pixel_pkg::PIX_W-1:0] null_cnt;
    logic [zs_pixel_pkg::PIX_W-1:0] pend_pix;
    logic                           is_null;
    logic                           close_run;
    logic                           emit_data;

    assign is_null = (pix_in == zs_pixel_pkg::NULL_PIXEL);

    // open run ends on a data pixel or on frame end
    assign close_run = (state == S_COUNT) && ((pix_valid_in && !is_null) || frame_end);

    // data pixel with no run open goes straight out
    assign emit_data = (state == S_IDLE) && pix_valid_in && !is_null;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            state    <= S_IDLE;
            null_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= close_run || emit_data || (state == S_HOLD);
            case (state)
                S_IDLE: begin
                    if (pix_valid_in && is_null) begin
                        null_cnt <= 1'b1;
                        state    <= S_COUNT;
                    end
                end
                S_COUNT: begin
                    if (pix_valid_in && is_null) begin
                        null_cnt <= null_cnt + 1'b1;
                    end else if (close_run) begin
                        null_cnt <= '0;
                        // a data pixel still has to follow the run word
                        state    <= frame_end ? S_IDLE : S_HOLD;
                    end
                end
                S_HOLD: begin
                    // input is idle here, the write port is free
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid_in) begin
            pend_pix <= pix_in;
        end
        if (close_run) begin
            wr_word.run.flag  <= zs_pixel_pkg::RUN_FLAG;
            wr_word.run.count <= null_cnt;
        end else if (state == S_HOLD) begin
            wr_word.data.flag  <= zs_pixel_pkg::DATA_FLAG;
            wr_word.data.pixel <= pend_pix;
        end else if (emit_data) begin
            wr_word.data.flag  <= zs_pixel_pkg::DATA_FLAG;
            wr_word.data.pixel <= pix_in;
        end
    end

endmodule

`default_nettype wire

// File: design/zs_read_if.sv
`timescale 1ns/10ps
`default_nettype none

interface zs_read_if;

    logic                              rd_en;
    zs_pixel_pkg::zs_word_u            rd_word;
    logic [zs_fifo_pkg::COUNT_W-1:0]   num_elem;
    logic                              empty;

    modport store (
        input  rd_en,
        output rd_word,
        output num_elem,
        output empty
    );

    modport expander (
        output rd_en,
        input  rd_word,
        input  empty
    );

endinterface

`default_nettype wire

// File: design/zs_fifo_pkg.sv
`default_nettype none

package zs_fifo_pkg;

    localparam int ADDR_W  = 9;
    localparam int DEPTH   = 512;
    localparam int COUNT_W = 9;
    // one slot is kept free so the count fits in COUNT_W bits
    localparam logic [COUNT_W-1:0] FULL_COUNT = 9'd511;

endpackage

`default_nettype wire

// File: design/zs_pixel_pkg.sv
`default_nettype none

package zs_pixel_pkg;

    // one readout pixel
    localparam int PIX_W = 21;

    // empty pixel, compressed into run words
    localparam logic [PIX_W-1:0] NULL_PIXEL = '0;

    // flag bit values of a stored word
    localparam logic DATA_FLAG = 1'b0;
    localparam logic RUN_FLAG  = 1'b1;

    // stored word, 22 bits, flag on top
    // flag 0 means the low bits are a pixel
    // flag 1 means the low bits count consecutive null pixels
    typedef union packed {
        struct packed {
            logic             flag;
            logic [PIX_W-1:0] pixel;
        } data;
        struct packed {
            logic             flag;
            logic [PIX_W-1:0] count;
        } run;
    } zs_word_u;

endpackage

`default_nettype wire
